// File: Bender.yml
package:
  name: wb8_soc

sources:
  # packages first, the peripheral package uses the map package
  - src/wb8_map_pkg.sv
  - src/wb8_periph_pkg.sv
  - src/wb8_bus_decoder.sv
  - src/wb8_ram.sv
  - src/wb8_gpio.sv
  - src/wb8_timer_regs.sv
  - src/wb8_timer_core.sv
  - src/wb8_soc.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_wb8_soc.sv

// File: src/wb8_bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module wb8_bus_decoder (
    input  wire                              clk,
    input  wire                              rst_n_i,
    input  wire                              cyc_i,
    input  wire                              stb_i,
    input  wire [wb8_map_pkg::ADDR_W-1:0]    adr_i,
    input  wire [wb8_map_pkg::DATA_W-1:0]    ram_dat_i,
    input  wire                              ram_ack_i,
    input  wire [wb8_map_pkg::DATA_W-1:0]    gpio_dat_i,
    input  wire                              gpio_ack_i,
    input  wire [wb8_map_pkg::DATA_W-1:0]    tmr_dat_i,
    input  wire                              tmr_ack_i,
    output logic                             ram_stb_o,
    output logic                             gpio_stb_o,
    output logic                             tmr_stb_o,
    output logic [wb8_map_pkg::DATA_W-1:0]   dat_o,
    output logic                             ack_o
);

    localparam int WIN_LSB = wb8_map_pkg::IO_PAGE_LSB + 3;

    logic       bus_stb;
    logic       io_hit;
    logic [2:0] page;
    logic       ram_sel, gpio_sel, tmr_sel, unm_sel;
    logic       ram_sel_q, gpio_sel_q, tmr_sel_q, unm_sel_q;
    logic       unm_ack_q;

    assign bus_stb = cyc_i & stb_i;
    assign io_hit  = adr_i[wb8_map_pkg::ADDR_W-1:WIN_LSB] ==
                     wb8_map_pkg::IO_BASE[wb8_map_pkg::ADDR_W-1:WIN_LSB];
    assign page    = adr_i[WIN_LSB-1:wb8_map_pkg::IO_PAGE_LSB];

    // everything outside the I/O window falls through to RAM
    assign ram_sel  = !io_hit;
    assign gpio_sel = io_hit && page == wb8_map_pkg::PAGE_GPIO;
    assign tmr_sel  = io_hit && page == wb8_map_pkg::PAGE_TIMER;
    assign unm_sel  = io_hit && !gpio_sel && !tmr_sel;

    assign ram_stb_o  = bus_stb & ram_sel;
    assign gpio_stb_o = bus_stb & gpio_sel;
    assign tmr_stb_o  = bus_stb & tmr_sel;

    // select follows the held address, ack of unmapped pages
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ram_sel_q  <= 1'b0;
            gpio_sel_q <= 1'b0;
            tmr_sel_q  <= 1'b0;
            unm_sel_q  <= 1'b0;
            unm_ack_q  <= 1'b0;
        end else begin
            ram_sel_q  <= ram_sel;
            gpio_sel_q <= gpio_sel;
            tmr_sel_q  <= tmr_sel;
            unm_sel_q  <= unm_sel;
            unm_ack_q  <= bus_stb & unm_sel & ~unm_ack_q;
        end
    end

    // return path
    always_comb begin
        dat_o = wb8_periph_pkg::UNMAPPED_DATA;
        ack_o = 1'b0;
        if (ram_sel_q) begin
            dat_o = ram_dat_i;
            ack_o = ram_ack_i;
        end else if (gpio_sel_q) begin
            dat_o = gpio_dat_i;
            ack_o = gpio_ack_i;
        end else if (tmr_sel_q) begin
            dat_o = tmr_dat_i;
            ack_o = tmr_ack_i;
        end else if (unm_sel_q) begin
            ack_o = unm_ack_q;
        end
    end

endmodule

`default_nettype wire

// File: src/wb8_gpio.sv
`timescale 1ns/1ps
`default_nettype none

module wb8_gpio (
    input  wire                                 clk,
    input  wire                                 rst_n_i,
    input  wire                                 stb_i,
    input  wire                                 we_i,
    input  wire [wb8_map_pkg::REG_ADDR_W-1:0]   adr_i,
    input  wire [wb8_map_pkg::DATA_W-1:0]       dat_i,
    input  wire [wb8_periph_pkg::GPIO_W-1:0]    pins_i,
    output logic [wb8_map_pkg::DATA_W-1:0]      dat_o,
    output logic                                ack_o,
    output logic [wb8_periph_pkg::GPIO_W-1:0]   pins_o,
    output logic                                irq_o
);

    logic [wb8_periph_pkg::GPIO_W-1:0] sync1_q, sync2_q, prev_q;
    logic [wb8_periph_pkg::GPIO_W-1:0] edge_q, irq_en_q;
    logic [wb8_periph_pkg::GPIO_W-1:0] rise, edge_clr;
    logic                              access, wr;

    assign access   = stb_i & ~ack_o;
    assign wr       = access & we_i;
    assign rise     = sync2_q & ~prev_q;
    assign edge_clr = (wr && adr_i == wb8_periph_pkg::GPIO_REG_EDGE) ? dat_i : '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q  <= '0;
            sync2_q  <= '0;
            prev_q   <= '0;
            pins_o   <= '0;
            irq_en_q <= '0;
            edge_q   <= '0;
            ack_o    <= 1'b0;
        end else begin
            sync1_q <= pins_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            ack_o   <= access;
            // a fresh edge beats a clear in the same cycle
            edge_q  <= (edge_q & ~edge_clr) | rise;
            if (wr && adr_i == wb8_periph_pkg::GPIO_REG_OUT) begin
                pins_o <= dat_i;
            end
            if (wr && adr_i == wb8_periph_pkg::GPIO_REG_IRQ_EN) begin
                irq_en_q <= dat_i;
            end
        end
    end

    // read data register
    always_ff @(posedge clk) begin
        if (access) begin
            case (adr_i)
                wb8_periph_pkg::GPIO_REG_OUT:  dat_o <= pins_o;
                wb8_periph_pkg::GPIO_REG_IN:   dat_o <= sync2_q;
                wb8_periph_pkg::GPIO_REG_EDGE: dat_o <= edge_q;
                default:                       dat_o <= irq_en_q;
            endcase
        end
    end

    assign irq_o = |(edge_q & irq_en_q);

endmodule

`default_nettype wire

// File: src/wb8_map_pkg.sv
`default_nettype none

package wb8_map_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 8;

    // I/O window, 2 KiB at the top of the address space
    localparam logic [ADDR_W-1:0] IO_BASE = 32'hFFFF_F800;

    // 3-bit page field inside the I/O window, address bits 10..8
    localparam int IO_PAGE_LSB = 8;

    // page indices of the mapped peripherals
    localparam logic [2:0] PAGE_GPIO  = 3'd0;
    localparam logic [2:0] PAGE_TIMER = 3'd5;

    // on-chip RAM, mirrored modulo its size everywhere outside the I/O window
    localparam int RAM_ADDR_W = 10;
    localparam int RAM_DEPTH  = 1024;

    // register offset width inside a peripheral page
    localparam int REG_ADDR_W = 2;

endpackage

`default_nettype wire

// File: src/wb8_periph_pkg.sv
`default_nettype none

package wb8_periph_pkg;

    localparam int GPIO_W = 8;

    // GPIO page offsets
    localparam logic [wb8_map_pkg::REG_ADDR_W-1:0] GPIO_REG_OUT    = 2'd0;
    localparam logic [wb8_map_pkg::REG_ADDR_W-1:0] GPIO_REG_IN     = 2'd1;
    localparam logic [wb8_map_pkg::REG_ADDR_W-1:0] GPIO_REG_EDGE   = 2'd2;
    localparam logic [wb8_map_pkg::REG_ADDR_W-1:0] GPIO_REG_IRQ_EN = 2'd3;

    // timer page offsets
    localparam logic [wb8_map_pkg::REG_ADDR_W-1:0] TMR_REG_CTRL   = 2'd0;
    localparam logic [wb8_map_pkg::REG_ADDR_W-1:0] TMR_REG_RELOAD = 2'd1;
    localparam logic [wb8_map_pkg::REG_ADDR_W-1:0] TMR_REG_COUNT  = 2'd2;
    localparam logic [wb8_map_pkg::REG_ADDR_W-1:0] TMR_REG_STATUS = 2'd3;

    // read value of the unmapped I/O pages
    localparam logic [wb8_map_pkg::DATA_W-1:0] UNMAPPED_DATA = 8'h00;

    // timer control fields, msb first
    typedef struct packed {
        logic [3:0] prescale;
        logic       rsvd;
        logic       irq_en;
        logic       auto_reload;
        logic       enable;
    } timer_ctrl_fields_t;

    // raw byte on the bus side, fields on the core side
    typedef union packed {
        logic [7:0]         raw;
        timer_ctrl_fields_t f;
    } timer_ctrl_t;

endpackage

`default_nettype wire

// File: src/wb8_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wb8_ram (
    input  wire                                clk,
    input  wire                                rst_n_i,
    input  wire                                stb_i,
    input  wire                                we_i,
    input  wire [wb8_map_pkg::RAM_ADDR_W-1:0]  adr_i,
    input  wire [wb8_map_pkg::DATA_W-1:0]      dat_i,
    output logic [wb8_map_pkg::DATA_W-1:0]     dat_o,
    output logic                               ack_o
);

    logic [wb8_map_pkg::DATA_W-1:0] mem [wb8_map_pkg::RAM_DEPTH];
    logic                           access;

    // one access per strobe, no second ack while the first is still up
    assign access = stb_i & ~ack_o;

    always_ff @(posedge clk) begin
        if (access) begin
            if (we_i) begin
                mem[adr_i] <= dat_i;
            end
            dat_o <= mem[adr_i];
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

endmodule

`default_nettype wire

// File: src/wb8_soc.sv
`timescale 1ns/1ps
`default_nettype none

module wb8_soc (
    input  wire                                clk,
    input  wire                                rst_n_i,
    input  wire                                cyc_i,
    input  wire                                stb_i,
    input  wire                                we_i,
    input  wire [wb8_map_pkg::ADDR_W-1:0]      adr_i,
    input  wire [wb8_map_pkg::DATA_W-1:0]      dat_i,
    input  wire [wb8_periph_pkg::GPIO_W-1:0]   pins_i,
    output wire [wb8_map_pkg::DATA_W-1:0]      dat_o,
    output wire                                ack_o,
    output wire [wb8_periph_pkg::GPIO_W-1:0]   pins_o,
    output wire                                timer_irq_o,
    output wire                                gpio_irq_o
);

    wire                               ram_stb, gpio_stb, tmr_stb;
    wire                               ram_ack, gpio_ack, tmr_ack;
    wire [wb8_map_pkg::DATA_W-1:0]     ram_dat, gpio_dat, tmr_dat;
    wb8_periph_pkg::timer_ctrl_t       tmr_ctrl;
    wire [wb8_map_pkg::DATA_W-1:0]     tmr_reload, tmr_count;
    wire                               tmr_load, tmr_expire;

    wb8_bus_decoder u_decoder (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .cyc_i      (cyc_i),
        .stb_i      (stb_i),
        .adr_i      (adr_i),
        .ram_dat_i  (ram_dat),
        .ram_ack_i  (ram_ack),
        .gpio_dat_i (gpio_dat),
        .gpio_ack_i (gpio_ack),
        .tmr_dat_i  (tmr_dat),
        .tmr_ack_i  (tmr_ack),
        .ram_stb_o  (ram_stb),
        .gpio_stb_o (gpio_stb),
        .tmr_stb_o  (tmr_stb),
        .dat_o      (dat_o),
        .ack_o      (ack_o)
    );

    wb8_ram u_ram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (ram_stb),
        .we_i    (we_i),
        .adr_i   (adr_i[wb8_map_pkg::RAM_ADDR_W-1:0]),
        .dat_i   (dat_i),
        .dat_o   (ram_dat),
        .ack_o   (ram_ack)
    );

    wb8_gpio u_gpio (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .stb_i   (gpio_stb),
        .we_i    (we_i),
        .adr_i   (adr_i[wb8_map_pkg::REG_ADDR_W-1:0]),
        .dat_i   (dat_i),
        .pins_i  (pins_i),
        .dat_o   (gpio_dat),
        .ack_o   (gpio_ack),
        .pins_o  (pins_o),
        .irq_o   (gpio_irq_o)
    );

    wb8_timer_regs u_timer_regs (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .stb_i    (tmr_stb),
        .we_i     (we_i),
        .adr_i    (adr_i[wb8_map_pkg::REG_ADDR_W-1:0]),
        .dat_i    (dat_i),
        .count_i  (tmr_count),
        .expire_i (tmr_expire),
        .dat_o    (tmr_dat),
        .ack_o    (tmr_ack),
        .ctrl_o   (tmr_ctrl),
        .reload_o (tmr_reload),
        .load_o   (tmr_load),
        .irq_o    (timer_irq_o)
    );

    wb8_timer_core u_timer_core (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .enable_i      (tmr_ctrl.f.enable),
        .auto_reload_i (tmr_ctrl.f.auto_reload),
        .prescale_i    (tmr_ctrl.f.prescale),
        .reload_i      (tmr_reload),
        .load_i        (tmr_load),
        .count_o       (tmr_count),
        .expire_o      (tmr_expire)
    );

endmodule

`default_nettype wire

// File: src/wb8_timer_core.sv
`timescale 1ns/1ps
`default_nettype none

module wb8_timer_core (
    input  wire                              clk,
    input  wire                              rst_n_i,
    input  wire                              enable_i,
    input  wire                              auto_reload_i,
    input  wire [3:0]                        prescale_i,
    input  wire [wb8_map_pkg::DATA_W-1:0]    reload_i,
    input  wire                              load_i,
    output logic [wb8_map_pkg::DATA_W-1:0]   count_o,
    output logic                             expire_o
);

    logic [3:0] pre_q;
    logic       run;
    logic       tick;

    // in one-shot mode hold still until the register block drops enable
    assign run  = enable_i & ~(expire_o & ~auto_reload_i);
    assign tick = run && pre_q == prescale_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pre_q    <= '0;
            count_o  <= '0;
            expire_o <= 1'b0;
        end else begin
            expire_o <= 1'b0;
            if (load_i) begin
                count_o <= reload_i;
                pre_q   <= '0;
            end else if (tick) begin
                pre_q <= '0;
                if (count_o == '0) begin
                    expire_o <= 1'b1;
                    count_o  <= reload_i;
                end else begin
                    count_o <= count_o - 1'b1;
                end
            end else if (run) begin
                pre_q <= pre_q + 1'b1;
            end else if (!enable_i) begin
                pre_q <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/wb8_timer_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb8_timer_regs (
    input  wire                                clk,
    input  wire                                rst_n_i,
    input  wire                                stb_i,
    input  wire                                we_i,
    input  wire [wb8_map_pkg::REG_ADDR_W-1:0]  adr_i,
    input  wire [wb8_map_pkg::DATA_W-1:0]      dat_i,
    input  wire [wb8_map_pkg::DATA_W-1:0]      count_i,
    input  wire                                expire_i,
    output logic [wb8_map_pkg::DATA_W-1:0]     dat_o,
    output logic                               ack_o,
    output wb8_periph_pkg::timer_ctrl_t        ctrl_o,
    output logic [wb8_map_pkg::DATA_W-1:0]     reload_o,
    output logic                               load_o,
    output logic                               irq_o
);

    logic access, wr;
    logic wr_ctrl, wr_reload, wr_status;
    logic expired_q;

    assign access    = stb_i & ~ack_o;
    assign wr        = access & we_i;
    assign wr_ctrl   = wr && adr_i == wb8_periph_pkg::TMR_REG_CTRL;
    assign wr_reload = wr && adr_i == wb8_periph_pkg::TMR_REG_RELOAD;
    assign wr_status = wr && adr_i == wb8_periph_pkg::TMR_REG_STATUS;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_o    <= '0;
            reload_o  <= '0;
            load_o    <= 1'b0;
            expired_q <= 1'b0;
            ack_o     <= 1'b0;
        end else begin
            ack_o  <= access;
            load_o <= wr_reload | (wr_ctrl & dat_i[0]);
            // one-shot expiry stops the timer, a CTRL write in the same cycle wins
            if (expire_i && !ctrl_o.f.auto_reload) begin
                ctrl_o.f.enable <= 1'b0;
            end
            if (wr_ctrl) begin
                ctrl_o.raw    <= dat_i;
                ctrl_o.f.rsvd <= 1'b0;
            end
            if (wr_reload) begin
                reload_o <= dat_i;
            end
            if (expire_i) begin
                expired_q <= 1'b1;
            end else if (wr_status && dat_i[0]) begin
                expired_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (adr_i)
                wb8_periph_pkg::TMR_REG_CTRL:   dat_o <= ctrl_o.raw;
                wb8_periph_pkg::TMR_REG_RELOAD: dat_o <= reload_o;
                wb8_periph_pkg::TMR_REG_COUNT:  dat_o <= count_i;
                default:                        dat_o <= {7'b0, expired_q};
            endcase
        end
    end

    assign irq_o = expired_q & ctrl_o.f.irq_en;

endmodule

`default_nettype wire

// File: tb/tb_wb8_tasks.svh
`ifndef TB_WB8_TASKS_SVH
`define TB_WB8_TASKS_SVH

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail at %0t ns: %s is 0x%0h, expected 0x%0h",
                               $time, name, got, exp));
        end
    endtask

    // page and register offset to a bus address in the I/O window
    function automatic logic [31:0] io_addr(input logic [2:0] page, input logic [1:0] off);
        return wb8_map_pkg::IO_BASE | ({29'd0, page} << wb8_map_pkg::IO_PAGE_LSB) |
               {30'd0, off};
    endfunction

    // one classic cycle, ack must be seen on the second rising edge
    task automatic bus_cycle(input logic we, input logic [31:0] adr,
                             input logic [7:0] wdat, output logic [7:0] rdat);
        int   edges;
        logic seen;
        edges = 0;
        seen  = 1'b0;
        @(negedge clk);
        cyc_i = 1'b1;
        stb_i = 1'b1;
        we_i  = we;
        adr_i = adr;
        dat_i = wdat;
        compare_value("ack_o before first edge", ack_o, 0);
        while (!seen && edges < 2) begin
            @(negedge clk);
            edges++;
            seen = ack_o;
        end
        if (!seen) begin
            fail_run($sformatf("bus cycle to 0x%0h got no ack within 2 cycles", adr));
        end else begin
            compare_value("ack_o latency", edges + 1, 2);
            rdat = dat_o;
            @(negedge clk);
            cyc_i = 1'b0;
            stb_i = 1'b0;
            we_i  = 1'b0;
            compare_value("ack_o after one cycle", ack_o, 0);
        end
    endtask

    task automatic wb_write(input logic [31:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [7:0] dat);
        bus_cycle(1'b0, adr, 8'h00, dat);
    endtask

    task automatic set_pins(input logic [7:0] v);
        @(negedge clk);
        pins_i = v;
        // two sync flops before IN sees the new value
        @(negedge clk);
    endtask

    task automatic wait_expired(input int bound);
        int         start;
        logic [7:0] status;
        start  = cycles;
        status = 8'h00;
        while (!status[0]) begin
            if (cycles - start > bound) begin
                fail_run("timer did not expire within the expected number of cycles");
            end else begin
                wb_read(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_STATUS),
                        status);
            end
        end
    endtask

    task automatic ram_readback();
        logic [31:0] adr [32];
        logic [7:0]  data [32];
        logic [7:0]  wr;
        logic [7:0]  rd;
        for (int i = 0; i < 32; i++) begin
            // odd stride keeps the low ten bits distinct
            adr[i] = (i << 16) | ((i * 309) & 32'h3ff);
            rand_byte(data[i]);
            wb_write(adr[i], data[i]);
        end
        for (int i = 0; i < 32; i++) begin
            wb_read(adr[i], rd);
            compare_value($sformatf("RAM[0x%0h]", adr[i]), rd, data[i]);
        end
        rand_byte(wr);
        wb_write(32'h0000_0200 + 32'd1024, wr);
        wb_read(32'h0000_0200, rd);
        compare_value("RAM mirror", rd, wr);
    endtask

    task automatic unmapped_pages();
        logic [31:0] adr;
        logic [7:0]  wr;
        logic [7:0]  rd;
        for (int p = 1; p < 8; p++) begin
            if (p != 5) begin
                adr = io_addr(p[2:0], p[1:0]);
                rand_byte(wr);
                wb_write(adr & 32'h3ff, wr ^ 8'h5a);
                wb_write(adr, wr);
                wb_read(adr, rd);
                compare_value("unmapped page data", rd, 8'h00);
                wb_read(adr & 32'h3ff, rd);
                compare_value("RAM below unmapped page", rd, wr ^ 8'h5a);
            end
        end
        compare_value("pins_o", pins_o, 8'h00);
        wb_read(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_RELOAD), rd);
        compare_value("timer RELOAD", rd, 8'h00);
    endtask

    task automatic gpio_port();
        logic [7:0] out_val;
        logic [7:0] pins;
        logic [7:0] nxt;
        logic [7:0] edges;
        logic [7:0] rd;
        rand_byte(out_val);
        wb_write(io_addr(wb8_map_pkg::PAGE_GPIO, wb8_periph_pkg::GPIO_REG_OUT), out_val);
        compare_value("pins_o", pins_o, out_val);
        wb_read(io_addr(wb8_map_pkg::PAGE_GPIO, wb8_periph_pkg::GPIO_REG_OUT), rd);
        compare_value("GPIO OUT", rd, out_val);
        wb_write(io_addr(wb8_map_pkg::PAGE_GPIO, wb8_periph_pkg::GPIO_REG_IRQ_EN), 8'h0f);
        pins  = 8'h00;
        edges = 8'h00;
        // rise on 4 and 5 (masked), then on 0, then everything falls
        for (int k = 0; k < 3; k++) begin
            nxt   = (k == 0) ? 8'h30 : (k == 1) ? 8'h31 : 8'h00;
            edges = edges | (nxt & ~pins);
            pins  = nxt;
            set_pins(pins);
            wb_read(io_addr(wb8_map_pkg::PAGE_GPIO, wb8_periph_pkg::GPIO_REG_IN), rd);
            compare_value("GPIO IN", rd, pins);
            wb_read(io_addr(wb8_map_pkg::PAGE_GPIO, wb8_periph_pkg::GPIO_REG_EDGE), rd);
            compare_value("GPIO EDGE", rd, edges);
            compare_value("gpio_irq_o", gpio_irq_o, |(edges & 8'h0f));
        end
        for (int k = 0; k < 2; k++) begin
            nxt   = (k == 0) ? 8'h01 : 8'h30;
            edges = edges & ~nxt;
            wb_write(io_addr(wb8_map_pkg::PAGE_GPIO, wb8_periph_pkg::GPIO_REG_EDGE), nxt);
            wb_read(io_addr(wb8_map_pkg::PAGE_GPIO, wb8_periph_pkg::GPIO_REG_EDGE), rd);
            compare_value("GPIO EDGE after clear", rd, edges);
            compare_value("gpio_irq_o", gpio_irq_o, 0);
        end
    endtask

    task automatic timer_oneshot();
        logic [7:0] reload;
        logic [3:0] pre;
        logic [7:0] rd;
        reload = 8'd12;
        pre    = 4'd3;
        wb_write(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_RELOAD), reload);
        // enable only, no auto-reload, no interrupt
        wb_write(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_CTRL),
                 {pre, 4'b0001});
        wait_expired((reload + 1) * (pre + 1) + 10);
        wb_read(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_CTRL), rd);
        compare_value("timer CTRL after one-shot", rd, {pre, 4'b0000});
        // counter reloaded on expiry and then holds
        for (int k = 0; k < 2; k++) begin
            wb_read(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_COUNT), rd);
            compare_value("timer COUNT after one-shot", rd, reload);
        end
        compare_value("timer_irq_o", timer_irq_o, 0);
        wb_write(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_CTRL),
                 {pre, 4'b0100});
        compare_value("timer_irq_o", timer_irq_o, 1);
        wb_write(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_STATUS), 8'h01);
        wb_read(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_STATUS), rd);
        compare_value("timer STATUS after clear", rd, 8'h00);
        compare_value("timer_irq_o", timer_irq_o, 0);
    endtask

    task automatic timer_autoreload();
        logic [7:0] reload;
        logic [3:0] pre;
        logic [7:0] rd;
        reload = 8'd6;
        pre    = 4'd1;
        wb_write(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_RELOAD), reload);
        // enable and auto-reload, reserved bit written as one
        wb_write(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_CTRL),
                 {pre, 4'b1011});
        wb_read(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_CTRL), rd);
        compare_value("timer CTRL reserved bit", rd[3], 0);
        for (int n = 0; n < 3; n++) begin
            wait_expired((reload + 1) * (pre + 1) + 10);
            wb_read(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_COUNT), rd);
            compare_value("timer COUNT within RELOAD", rd <= reload, 1);
            wb_write(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_STATUS), 8'h01);
        end
        wb_read(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_CTRL), rd);
        compare_value("timer CTRL enable", rd[0], 1);
        wb_write(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_CTRL), 8'h00);
        wb_write(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_STATUS), 8'h01);
    endtask

`endif

// File: tb/tb_wb8_soc.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb8_soc;

    // summed worst case of all tests is well under this, kept with wide margin
    localparam int          CYCLE_LIMIT = 4000;
    localparam logic [31:0] LFSR_SEED   = 32'h2a2b_f5a3;

    logic        clk;
    logic        rst_n_i;
    logic        cyc_i;
    logic        stb_i;
    logic        we_i;
    logic [31:0] adr_i;
    logic [7:0]  dat_i;
    logic [7:0]  pins_i;
    wire  [7:0]  dat_o;
    wire         ack_o;
    wire  [7:0]  pins_o;
    wire         timer_irq_o;
    wire         gpio_irq_o;

    logic [31:0] lfsr_q;
    int          cycles = 0;

    wb8_soc DUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cyc_i       (cyc_i),
        .stb_i       (stb_i),
        .we_i        (we_i),
        .adr_i       (adr_i),
        .dat_i       (dat_i),
        .pins_i      (pins_i),
        .dat_o       (dat_o),
        .ack_o       (ack_o),
        .pins_o      (pins_o),
        .timer_irq_o (timer_irq_o),
        .gpio_irq_o  (gpio_irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // watchdog on the whole run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run("run did not finish within the cycle limit");
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    task automatic rand_byte(output logic [7:0] b);
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            b = {b[6:0], lfsr_q[0]};
        end
    endtask

    `include "tb_wb8_tasks.svh"

    task automatic reset_values();
        logic [7:0] rd;
        compare_value("ack_o", ack_o, 0);
        compare_value("ram_stb", DUT.ram_stb, 0);
        compare_value("gpio_stb", DUT.gpio_stb, 0);
        compare_value("tmr_stb", DUT.tmr_stb, 0);
        compare_value("pins_o", pins_o, 0);
        compare_value("timer_irq_o", timer_irq_o, 0);
        compare_value("gpio_irq_o", gpio_irq_o, 0);
        wb_read(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_CTRL), rd);
        compare_value("timer CTRL", rd, 8'h00);
        wb_read(io_addr(wb8_map_pkg::PAGE_TIMER, wb8_periph_pkg::TMR_REG_COUNT), rd);
        compare_value("timer COUNT", rd, 8'h00);
    endtask

    initial begin
        rst_n_i = 1'b0;
        cyc_i   = 1'b0;
        stb_i   = 1'b0;
        we_i    = 1'b0;
        adr_i   = 32'h0;
        dat_i   = 8'h00;
        pins_i  = 8'h00;
        lfsr_q  = LFSR_SEED;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        reset_values();
        ram_readback();
        unmapped_pages();
        gpio_port();
        timer_oneshot();
        timer_autoreload();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: wb8_soc.f
+incdir+tb
src/wb8_map_pkg.sv
src/wb8_periph_pkg.sv
src/wb8_bus_decoder.sv
src/wb8_ram.sv
src/wb8_gpio.sv
src/wb8_timer_regs.sv
src/wb8_timer_core.sv
src/wb8_soc.sv
tb/tb_wb8_soc.sv
